/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    // architectural widths for RV32I
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [31:0]          instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes, shared between OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7: base encoding and the alternate one for SUB / SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* logic/exec_cfg_pkg.sv */
package exec_cfg_pkg;

    // input queue entries, also the sender's credits after reset
    localparam int QUEUE_DEPTH = 4;

    // output credits held by the pipe after reset
    localparam int OUT_CREDITS = 2;

    // derived widths
    localparam int Q_PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int Q_CNT_W   = $clog2(QUEUE_DEPTH + 1);
    localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

    typedef logic [Q_PTR_W-1:0]   q_ptr_t;
    // must hold 0..QUEUE_DEPTH
    typedef logic [Q_CNT_W-1:0]   q_cnt_t;
    // must hold 0..OUT_CREDITS
    typedef logic [OUT_CNT_W-1:0] out_cnt_t;

endpackage

/* logic/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  rv_isa_pkg::instr_t in_instr,
    input  logic               pop,
    output logic               q_valid,
    output rv_isa_pkg::instr_t q_instr,
    output logic               credit_return
);

    // storage, no reset needed on the payload
    rv_isa_pkg::instr_t mem [exec_cfg_pkg::QUEUE_DEPTH];

    exec_cfg_pkg::q_ptr_t wr_ptr;
    exec_cfg_pkg::q_ptr_t rd_ptr;
    exec_cfg_pkg::q_cnt_t count;
    // pop only counts when there is something to pop
    logic                 do_pop;

    assign do_pop  = pop && q_valid;
    assign q_valid = (count != '0);
    // head of queue goes straight to the decoder
    assign q_instr = mem[rd_ptr];

    // credits guarantee space, so every beat is written
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                // wrap explicitly in case depth is not a power of two
                if (wr_ptr == exec_cfg_pkg::q_ptr_t'(exec_cfg_pkg::QUEUE_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == exec_cfg_pkg::q_ptr_t'(exec_cfg_pkg::QUEUE_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // occupancy: push and pop in one cycle cancel
            if (in_valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (!in_valid && do_pop) begin
                count <= count - 1'b1;
            end
            // one credit back to the sender per released entry
            credit_return <= do_pop;
        end
    end

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  rv_isa_pkg::instr_t   instr,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd,
    output rv_isa_pkg::xlen_t    imm,
    output logic                 use_imm,
    output logic                 zero_rs1,
    output rv_isa_pkg::alu_op_e  alu_op,
    output logic                 illegal
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_isa_pkg::xlen_t   imm_i;
    rv_isa_pkg::xlen_t   imm_u;
    logic                is_lui;
    // base operation from funct3 alone
    rv_isa_pkg::alu_op_e f3_op;

    // fixed field positions
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // I-type immediate, sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    // U-type immediate for LUI
    assign imm_u = {instr[31:12], 12'b0};

    assign is_lui   = (opcode == rv_isa_pkg::OPC_LUI);
    assign imm      = is_lui ? imm_u : imm_i;
    // LUI has no rs1, operand 1 forced to zero
    assign zero_rs1 = is_lui;

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_ADD_SUB: f3_op = rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     f3_op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     f3_op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    f3_op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     f3_op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:      f3_op = rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      f3_op = rv_isa_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:     f3_op = rv_isa_pkg::ALU_AND;
            default:                f3_op = rv_isa_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op  = f3_op;
        use_imm = 1'b0;
        illegal = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                // register form: funct7 alt only valid for SUB and SRA
                if (funct7 == rv_isa_pkg::F7_ALT) begin
                    if (funct3 == rv_isa_pkg::F3_ADD_SUB) begin
                        alu_op = rv_isa_pkg::ALU_SUB;
                    end else if (funct3 == rv_isa_pkg::F3_SR) begin
                        alu_op = rv_isa_pkg::ALU_SRA;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 != rv_isa_pkg::F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // funct7 only matters for the shift immediates
                if (funct3 == rv_isa_pkg::F3_SLL) begin
                    illegal = (funct7 != rv_isa_pkg::F7_BASE);
                end else if (funct3 == rv_isa_pkg::F3_SR) begin
                    if (funct7 == rv_isa_pkg::F7_ALT) begin
                        alu_op = rv_isa_pkg::ALU_SRA;
                    end else if (funct7 != rv_isa_pkg::F7_BASE) begin
                        illegal = 1'b1;
                    end
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op  = rv_isa_pkg::ALU_PASS_B;
                use_imm = 1'b1;
            end
            default: begin
                // everything else is outside this slice
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::xlen_t    rdata1,
    output rv_isa_pkg::xlen_t    rdata2,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t wd_idx,
    input  rv_isa_pkg::xlen_t    wdata
);

    // x0 has no storage
    rv_isa_pkg::xlen_t regs [1:31];

    // combinational reads, index 0 hardwired to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd_idx != '0)) begin
            // writes to x0 are dropped
            regs[wd_idx] <= wdata;
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_isa_pkg::xlen_t   op1,
    input  rv_isa_pkg::xlen_t   op2,
    input  rv_isa_pkg::alu_op_e op,
    output rv_isa_pkg::xlen_t   res
);

    // RV32 shifts take only the low 5 bits
    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (op)
            rv_isa_pkg::ALU_ADD:    res = $signed(op1) + $signed(op2);
            rv_isa_pkg::ALU_SUB:    res = $signed(op1) - $signed(op2);
            // compares give 0 or 1
            rv_isa_pkg::ALU_SLT:    res = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
            rv_isa_pkg::ALU_SLTU:   res = (op1 < op2) ? 32'd1 : 32'd0;
            rv_isa_pkg::ALU_XOR:    res = op1 ^ op2;
            rv_isa_pkg::ALU_OR:     res = op1 | op2;
            rv_isa_pkg::ALU_AND:    res = op1 & op2;
            rv_isa_pkg::ALU_SLL:    res = op1 << shamt;
            rv_isa_pkg::ALU_SRL:    res = op1 >> shamt;
            // arithmetic shift keeps the sign
            rv_isa_pkg::ALU_SRA:    res = $signed(op1) >>> shamt;
            // LUI path
            rv_isa_pkg::ALU_PASS_B: res = op2;
            default:                res = '0;
        endcase
    end

endmodule

/* logic/exec_pipe.sv */
`timescale 1ns/1ps

module exec_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    // instruction queue side
    input  logic                 q_valid,
    output logic                 q_pop,
    // decoded fields of the head instruction
    input  rv_isa_pkg::reg_idx_t dec_rd,
    input  rv_isa_pkg::xlen_t    dec_imm,
    input  logic                 dec_use_imm,
    input  logic                 dec_zero_rs1,
    input  rv_isa_pkg::alu_op_e  dec_alu_op,
    input  logic                 dec_illegal,
    // register file reads
    input  rv_isa_pkg::xlen_t    rdata1,
    input  rv_isa_pkg::xlen_t    rdata2,
    // alu
    output rv_isa_pkg::xlen_t    alu_op1,
    output rv_isa_pkg::xlen_t    alu_op2,
    output rv_isa_pkg::alu_op_e  alu_op_sel,
    input  rv_isa_pkg::xlen_t    alu_res,
    // writeback
    output logic                 rf_we,
    output rv_isa_pkg::reg_idx_t rf_idx,
    output rv_isa_pkg::xlen_t    rf_wdata,
    // output port
    output logic                 out_valid,
    output rv_isa_pkg::reg_idx_t out_rd,
    output rv_isa_pkg::xlen_t    out_data,
    output logic                 out_illegal,
    input  logic                 out_credit
);

    // output credits not yet spent
    exec_cfg_pkg::out_cnt_t credit_cnt;
    logic                   has_credit;

    assign has_credit = (credit_cnt != '0);
    // issue only when downstream has room, else the item waits in the queue
    assign q_pop      = q_valid && has_credit;

    // operand select
    assign alu_op1    = dec_zero_rs1 ? '0 : rdata1;
    assign alu_op2    = dec_use_imm ? dec_imm : rdata2;
    assign alu_op_sel = dec_alu_op;

    // writeback on the pop edge, same edge as the result register,
    // so the next issued instruction already reads the new value
    assign rf_we    = q_pop && !dec_illegal && (dec_rd != '0);
    assign rf_idx   = dec_rd;
    assign rf_wdata = alu_res;

    // credit counter, pop and return may coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= exec_cfg_pkg::out_cnt_t'(exec_cfg_pkg::OUT_CREDITS);
        end else begin
            case ({q_pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= q_pop;
        end
    end

    // result payload, loaded on issue only
    always_ff @(posedge clk) begin
        if (q_pop) begin
            out_rd      <= dec_rd;
            out_illegal <= dec_illegal;
            // illegal instructions report zero data
            out_data    <= dec_illegal ? '0 : alu_res;
        end
    end

endmodule

/* logic/exec_unit_top.sv */
`timescale 1ns/1ps

module exec_unit_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rv_isa_pkg::instr_t   in_instr,
    output logic                 in_credit,
    output logic                 out_valid,
    output rv_isa_pkg::reg_idx_t out_rd,
    output rv_isa_pkg::xlen_t    out_data,
    output logic                 out_illegal,
    input  logic                 out_credit
);

    // queue to pipe
    logic                 q_valid;
    logic                 q_pop;
    rv_isa_pkg::instr_t   q_instr;

    // decoder outputs
    rv_isa_pkg::reg_idx_t dec_rs1;
    rv_isa_pkg::reg_idx_t dec_rs2;
    rv_isa_pkg::reg_idx_t dec_rd;
    rv_isa_pkg::xlen_t    dec_imm;
    logic                 dec_use_imm;
    logic                 dec_zero_rs1;
    rv_isa_pkg::alu_op_e  dec_alu_op;
    logic                 dec_illegal;

    // register file and alu
    rv_isa_pkg::xlen_t    rdata1;
    rv_isa_pkg::xlen_t    rdata2;
    rv_isa_pkg::xlen_t    alu_op1;
    rv_isa_pkg::xlen_t    alu_op2;
    rv_isa_pkg::alu_op_e  alu_op_sel;
    rv_isa_pkg::xlen_t    alu_res;
    logic                 rf_we;
    rv_isa_pkg::reg_idx_t rf_idx;
    rv_isa_pkg::xlen_t    rf_wdata;

    instr_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .pop           (q_pop),
        .q_valid       (q_valid),
        .q_instr       (q_instr),
        .credit_return (in_credit)
    );

    instr_decoder u_dec (
        .instr    (q_instr),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd       (dec_rd),
        .imm      (dec_imm),
        .use_imm  (dec_use_imm),
        .zero_rs1 (dec_zero_rs1),
        .alu_op   (dec_alu_op),
        .illegal  (dec_illegal)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .wd_idx (rf_idx),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .op1 (alu_op1),
        .op2 (alu_op2),
        .op  (alu_op_sel),
        .res (alu_res)
    );

    exec_pipe u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .q_valid      (q_valid),
        .q_pop        (q_pop),
        .dec_rd       (dec_rd),
        .dec_imm      (dec_imm),
        .dec_use_imm  (dec_use_imm),
        .dec_zero_rs1 (dec_zero_rs1),
        .dec_alu_op   (dec_alu_op),
        .dec_illegal  (dec_illegal),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .alu_op1      (alu_op1),
        .alu_op2      (alu_op2),
        .alu_op_sel   (alu_op_sel),
        .alu_res      (alu_res),
        .rf_we        (rf_we),
        .rf_idx       (rf_idx),
        .rf_wdata     (rf_wdata),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_data     (out_data),
        .out_illegal  (out_illegal),
        .out_credit   (out_credit)
    );

endmodule

/* testbench/exec_unit_checker.sv */
`timescale 1ns/1ps

module exec_unit_checker (
    input logic                   clk,
    input logic                   rst_n,
    // pipe side
    input logic                   out_valid,
    input exec_cfg_pkg::out_cnt_t credit_cnt,
    input logic                   rf_we,
    input rv_isa_pkg::reg_idx_t   rf_idx,
    // queue side
    input logic                   q_in_valid,
    input exec_cfg_pkg::q_cnt_t   q_count
);

    // result register stays quiet while reset is held
    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // out_valid follows the pop by one edge, so a zero count must block the next beat
    assert property (@(posedge clk) disable iff (!rst_n)
        (credit_cnt == '0) |=> !out_valid)
        else $error("out_valid issued without an output credit");

    // returned credits never pile up beyond the initial count
    assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= exec_cfg_pkg::out_cnt_t'(exec_cfg_pkg::OUT_CREDITS))
        else $error("output credit count above its maximum");

    // x0 is never a write target
    assert property (@(posedge clk) disable iff (!rst_n) !(rf_we && rf_idx == '0))
        else $error("register file write to x0");

    // sender only sends with a credit, so a full queue never sees a beat
    assert property (@(posedge clk) disable iff (!rst_n)
        !(q_in_valid && q_count == exec_cfg_pkg::q_cnt_t'(exec_cfg_pkg::QUEUE_DEPTH)))
        else $error("write into a full instruction queue");

endmodule

// pipe instance, queue inputs tied off
bind exec_pipe exec_unit_checker pipe_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .credit_cnt (credit_cnt),
    .rf_we      (rf_we),
    .rf_idx     (rf_idx),
    .q_in_valid (1'b0),
    .q_count    ('0)
);

// queue instance, pipe inputs tied off
bind instr_queue exec_unit_checker queue_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (1'b0),
    .credit_cnt ('0),
    .rf_we      (1'b0),
    .rf_idx     ('0),
    .q_in_valid (in_valid),
    .q_count    (count)
);

/* testbench/tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit;

    localparam int WAIT_LIMIT = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    rv_isa_pkg::instr_t   in_instr;
    logic                 in_credit;
    logic                 out_valid;
    rv_isa_pkg::reg_idx_t out_rd;
    rv_isa_pkg::xlen_t    out_data;
    logic                 out_illegal;
    // only the monitor drives this one
    logic                 out_credit = 1'b0;

    // instruction table with one entry per row in every queue
    rv_isa_pkg::instr_t   row_instr[$];
    rv_isa_pkg::reg_idx_t row_rd[$];
    rv_isa_pkg::xlen_t    row_data[$];
    logic                 row_ill[$];
    int                   row_gap[$];
    int                   row_delay[$];

    int errors           = 0;
    int seen             = 0;
    int beats_sent       = 0;
    int credits_returned = 0;
    int credits_given    = 0;
    bit hung             = 1'b0;
    // countdowns for output credits still owed to the DUT
    int owed[$];

    exec_unit_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_illegal (out_illegal),
        .out_credit  (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rv_isa_pkg::instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                  input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic rv_isa_pkg::instr_t i_type(input logic [2:0] f3, input logic [4:0] rd,
                                                  input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_isa_pkg::instr_t u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    // credits the sender holds right now
    function automatic int sender_credits();
        return exec_cfg_pkg::QUEUE_DEPTH + credits_returned - beats_sent;
    endfunction

    task automatic add_row(input rv_isa_pkg::instr_t instr, input logic [4:0] rd,
                           input logic [31:0] data, input logic ill);
        row_instr.push_back(instr);
        row_rd.push_back(rd);
        row_data.push_back(data);
        row_ill.push_back(ill);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        hung = 1'b1;
        $display("timed out waiting for %s", what);
    endtask

    task automatic build_table();
        // constants including sign-extended immediates
        add_row(u_type(5'd1, 20'h12345), 5'd1, 32'h1234_5000, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd1, 12'h678), 5'd1, 32'h1234_5678, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd2, 5'd0, 12'hFFF), 5'd2, 32'hFFFF_FFFF, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'h800), 5'd3, 32'hFFFF_F800, 1'b0);
        add_row(u_type(5'd4, 20'h7FFFF), 5'd4, 32'h7FFF_F000, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd4, 5'd4, 12'h7FF), 5'd4, 32'h7FFF_F7FF, 1'b0);
        // register pairs where add wraps past the signed maximum
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd5, 5'd4, 5'd4),
                5'd5, 32'hFFFF_EFFE, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 5'd6, 5'd0, 5'd1),
                5'd6, 32'hEDCB_A988, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 5'd7, 5'd1, 5'd2),
                5'd7, 32'hEDCB_A987, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 5'd8, 5'd1, 5'd3),
                5'd8, 32'hFFFF_FE78, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 5'd9, 5'd1, 5'd3),
                5'd9, 32'h1234_5000, 1'b0);
        // signed and unsigned order disagree for -1 against a positive value
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, 5'd10, 5'd2, 5'd1),
                5'd10, 32'h1, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLTU, 5'd11, 5'd2, 5'd1),
                5'd11, 32'h0, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SLTU, 5'd12, 5'd1, 12'hFFF), 5'd12, 32'h1, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SLT, 5'd28, 5'd2, 12'h000), 5'd28, 32'h1, 1'b0);
        // shift amount 36 of which only the low 5 bits (4) count
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd13, 5'd0, 12'd36), 5'd13, 32'h24, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 5'd14, 5'd1, 5'd13),
                5'd14, 32'h2345_6780, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SR, 5'd15, 5'd2, 5'd13),
                5'd15, 32'h0FFF_FFFF, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR, 5'd16, 5'd3, 5'd13),
                5'd16, 32'hFFFF_FF80, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SR, 5'd17, 5'd8, {rv_isa_pkg::F7_ALT, 5'd8}),
                5'd17, 32'hFFFF_FFFE, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SR, 5'd18, 5'd1, 12'd16), 5'd18, 32'h0000_1234, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SLL, 5'd19, 5'd4, 12'd31), 5'd19, 32'h8000_0000, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_SR, 5'd27, 5'd4, {rv_isa_pkg::F7_ALT, 5'd4}),
                5'd27, 32'h07FF_FF7F, 1'b0);
        // x0 target is reported but not written
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd0, 5'd1, 12'd5), 5'd0, 32'h1234_567D, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd20, 5'd0, 5'd0),
                5'd20, 32'h0, 1'b0);
        // illegal load opcode, MUL funct7, SLLI with bit 25 set and XOR with alt funct7
        add_row({12'h004, 5'd1, 3'b010, 5'd21, 7'b0000011}, 5'd21, 32'h0, 1'b1);
        add_row(r_type(7'h01, rv_isa_pkg::F3_ADD_SUB, 5'd21, 5'd1, 5'd1), 5'd21, 32'h0, 1'b1);
        add_row(i_type(rv_isa_pkg::F3_SLL, 5'd21, 5'd1, {7'h01, 5'd1}), 5'd21, 32'h0, 1'b1);
        add_row(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_XOR, 5'd21, 5'd1, 5'd2),
                5'd21, 32'h0, 1'b1);
        // x21 and x1 untouched by the illegal rows
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd22, 5'd21, 12'h000), 5'd22, 32'h0, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_ADD_SUB, 5'd23, 5'd1, 12'h000), 5'd23, 32'h1234_5678, 1'b0);
        // dependent chain through x25
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd25, 5'd1, 5'd1),
                5'd25, 32'h2468_ACF0, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd25, 5'd25, 5'd1),
                5'd25, 32'h369D_0368, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 5'd26, 5'd25, 5'd25),
                5'd26, 32'h0, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_XOR, 5'd29, 5'd1, 12'hFFF), 5'd29, 32'hEDCB_A987, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_OR, 5'd30, 5'd0, 12'h555), 5'd30, 32'h555, 1'b0);
        add_row(i_type(rv_isa_pkg::F3_AND, 5'd31, 5'd2, 12'h0F0), 5'd31, 32'hF0, 1'b0);
        add_row(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd24, 5'd0, 5'd5),
                5'd24, 32'hFFFF_EFFE, 1'b0);
    endtask

    // credits handed back by the queue
    always @(posedge clk) begin
        if (in_credit) begin
            credits_returned <= credits_returned + 1;
        end
    end

    // monitor checks each result and returns its credit after a random delay
    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (out_valid) begin
            if (seen < row_instr.size()) begin
                check_value("out_rd", out_rd, row_rd[seen]);
                check_value("out_data", out_data, row_data[seen]);
                check_value("out_illegal", out_illegal, row_ill[seen]);
                owed.push_back(row_delay[seen]);
            end else begin
                errors++;
                $display("an output beat arrived after the last table row");
            end
            seen <= seen + 1;
        end
        if (owed.size() > 0) begin
            if (owed[0] == 0) begin
                out_credit    <= 1'b1;
                credits_given <= credits_given + 1;
                owed.delete(0);
            end else begin
                owed[0] = owed[0] - 1;
            end
        end
    end

    initial begin
        int wait_cnt;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        void'($urandom(32'h994a_93ec));
        build_table();
        // mostly back-to-back beats with credit delays long enough to fill the queue
        foreach (row_instr[i]) begin
            row_gap.push_back(($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0);
            row_delay.push_back($urandom_range(0, 6));
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        foreach (row_instr[i]) begin
            repeat (row_gap[i]) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            wait_cnt = 0;
            // hold the beat until the sender owns a credit
            while (sender_credits() == 0 && !hung) begin
                in_valid <= 1'b0;
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    report_timeout("an input credit");
                end
            end
            if (hung) begin
                break;
            end
            in_valid   <= 1'b1;
            in_instr   <= row_instr[i];
            beats_sent++;
        end
        @(posedge clk);
        in_valid <= 1'b0;

        wait_cnt = 0;
        while (seen < row_instr.size() && !hung) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                report_timeout("the remaining results");
            end
        end
        wait_cnt = 0;
        while (sender_credits() != exec_cfg_pkg::QUEUE_DEPTH && !hung) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                report_timeout("the input credits to come back");
            end
        end
        wait_cnt = 0;
        while (credits_given < row_instr.size() && !hung) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                report_timeout("the output credits to be returned");
            end
        end
        // idle tail catches stray beats
        repeat (5) @(posedge clk);
        check_value("sender_credits", sender_credits(), exec_cfg_pkg::QUEUE_DEPTH);

        $display("run finished: %0d results seen, %0d errors", seen, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/rv_isa_pkg.sv
logic/exec_cfg_pkg.sv
logic/instr_queue.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_pipe.sv
logic/exec_unit_top.sv
testbench/exec_unit_checker.sv
testbench/tb_exec_unit.sv
